/* verilog/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_WIDTH 8

`define CPU_SP_RESET 8'hF0

// Opcode register content out of reset
`define CPU_NOP_BYTE 8'hFE

// Bit positions in FLAGS
// Bits 5 to 7 stay zero
`define CPU_FLAG_CARRY     0
`define CPU_FLAG_ZERO      1
`define CPU_FLAG_SIGN      2
`define CPU_FLAG_OVERFLOW  3
`define CPU_FLAG_UNDERFLOW 4

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_WIDTH-1:0] word_t;

  typedef enum logic [2:0] {
    RESET_STAGE,
    FETCH_OPERATION,
    DECODE,
    FETCH_OPERANDS,
    EXECUTE,
    WRITE_REGISTER,
    WRITE_MEMORY,
    HALTED
  } stage_t;

  // Illegal bytes decode to HLT
  typedef enum logic [2:0] {MOV, ADD, CMP, JMP, NOP, HLT} opcode_t;

  typedef enum logic [2:0] {UNUSED, REG_A, REG_SP, IMM, ADDRESS_IMM} operand_t;

  typedef enum logic [1:0] {MEMORY_STAY, MEMORY_READ, MEMORY_WRITE} mem_ctrl_t;

  // MOV, ADD, CMP layout
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] dst;
    logic [2:0] src;
  } two_op_t;

  // Class 11 layout
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] group;
    logic [2:0] sel;
  } misc_t;

  typedef union packed {
    two_op_t two_op;
    misc_t   misc;
  } instr_u;

endpackage

`default_nettype wire

/* verilog/sequencer.sv */
`default_nettype none

module sequencer import cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  logic     fetch_done
  , input  logic     store_done
  , input  opcode_t  decode_ope
  , input  operand_t decode_dst
  , output stage_t   stage
  , output logic     halted
);

  stage_t next_stage;

  always_comb begin
    case (stage)
      RESET_STAGE:     next_stage = FETCH_OPERATION;
      FETCH_OPERATION: next_stage = fetch_done ? DECODE : FETCH_OPERATION;
      DECODE:          next_stage = FETCH_OPERANDS;
      FETCH_OPERANDS:  next_stage = fetch_done ? EXECUTE : FETCH_OPERANDS;
      EXECUTE:         next_stage = (decode_ope == HLT) ? HALTED : WRITE_REGISTER;
      WRITE_REGISTER: begin
        // CMP never stores its result
        if ((decode_dst == ADDRESS_IMM) && (decode_ope != CMP)) begin
          next_stage = WRITE_MEMORY;
        end else begin
          next_stage = FETCH_OPERATION;
        end
      end
      WRITE_MEMORY:    next_stage = store_done ? FETCH_OPERATION : WRITE_MEMORY;
      default:         next_stage = HALTED;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= RESET_STAGE;
    end else begin
      stage <= next_stage;
    end
  end

  // Parked until the next reset
  assign halted = (stage == HALTED);

  // Only one RESET_STAGE cycle per reset
  a_no_reset_stage: assert property (
    @(posedge CLOCK) disable iff (RESET)
    ($past(RESET) == 1'b0) |-> (stage != RESET_STAGE)
  );

endmodule

`default_nettype wire

/* verilog/operand_fetch.sv */
`default_nettype none

`include "cpu_settings.svh"

module operand_fetch import cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  stage_t   stage
  , input  word_t    read_bus
  , input  opcode_t  decode_ope
  , input  operand_t decode_src
  , input  operand_t decode_dst
  , output logic     fetch_done
  , output word_t    opcode_byte
  , output word_t    imm
  , output word_t    mem_src
  , output word_t    mem_dst
  , output word_t    dst_addr
  , output word_t    read_addr
  , output logic     reading
);

  localparam logic [2:0] STEP_NONE     = 3'd0;
  localparam logic [2:0] STEP_IMM      = 3'd1;
  localparam logic [2:0] STEP_SRC_ADDR = 3'd2;
  localparam logic [2:0] STEP_SRC_DATA = 3'd3;
  localparam logic [2:0] STEP_DST_ADDR = 3'd4;
  localparam logic [2:0] STEP_DST_DATA = 3'd5;

  word_t      ip;
  word_t      src_addr;
  logic       phase;
  logic       capture;
  logic       operand_stage;
  logic       advance_ip;
  logic [2:0] step;
  logic [2:0] dst_first;
  logic [2:0] first_step;
  logic [2:0] cur_step;
  logic [2:0] next_step;

  assign operand_stage = (stage == FETCH_OPERANDS);

  // First read is chosen straight from the decoded modes, no idle cycle
  always_comb begin
    dst_first = (decode_dst == ADDRESS_IMM) ? STEP_DST_ADDR : STEP_NONE;
    case (decode_src)
      IMM:         first_step = STEP_IMM;
      ADDRESS_IMM: first_step = STEP_SRC_ADDR;
      default:     first_step = dst_first;
    endcase
    if (!operand_stage) begin
      cur_step = STEP_NONE;
    end else if (step == STEP_NONE) begin
      cur_step = first_step;
    end else begin
      cur_step = step;
    end
    case (cur_step)
      STEP_SRC_ADDR:           next_step = STEP_SRC_DATA;
      STEP_DST_ADDR:           next_step = STEP_DST_DATA;
      STEP_IMM, STEP_SRC_DATA: next_step = dst_first;
      default:                 next_step = STEP_NONE;
    endcase
    case (cur_step)
      STEP_SRC_DATA: read_addr = src_addr;
      STEP_DST_DATA: read_addr = dst_addr;
      default:       read_addr = ip;
    endcase
  end

  assign reading = (stage == FETCH_OPERATION) || (cur_step != STEP_NONE);
  assign capture = reading && phase;

  assign fetch_done = ((stage == FETCH_OPERATION) && phase) ||
                      (operand_stage && ((cur_step == STEP_NONE) ||
                                         (phase && (next_step == STEP_NONE))));

  // Opcode and in-line bytes move the pointer, data reads do not
  assign advance_ip = capture && ((stage == FETCH_OPERATION) ||
                                  (cur_step == STEP_IMM) ||
                                  (cur_step == STEP_SRC_ADDR) ||
                                  (cur_step == STEP_DST_ADDR));

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase       <= 1'b0;
      step        <= STEP_NONE;
      ip          <= '0;
      opcode_byte <= `CPU_NOP_BYTE;
    end else begin
      phase <= reading && !phase;
      if (capture && operand_stage) begin
        step <= next_step;
      end
      if (capture && (stage == FETCH_OPERATION)) begin
        opcode_byte <= read_bus;
      end
      if (advance_ip) begin
        ip <= ip + 1'b1;
      end else if ((stage == EXECUTE) && (decode_ope == JMP)) begin
        ip <= ip + imm;
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (capture) begin
      case (cur_step)
        STEP_IMM:      imm      <= read_bus;
        STEP_SRC_ADDR: src_addr <= read_bus;
        STEP_SRC_DATA: mem_src  <= read_bus;
        STEP_DST_ADDR: dst_addr <= read_bus;
        STEP_DST_DATA: mem_dst  <= read_bus;
        default: begin
        end
      endcase
    end
  end

  // Memory must answer within the two-cycle read
  a_read_known: assert property (
    @(posedge CLOCK) disable iff (RESET)
    capture |-> !$isunknown(read_bus)
  );

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`default_nettype none

module decoder import cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  stage_t   stage
  , input  word_t    opcode_byte
  , output opcode_t  decode_ope
  , output operand_t decode_src
  , output operand_t decode_dst
);

  instr_u   ins;
  opcode_t  next_ope;
  operand_t next_src;
  operand_t next_dst;
  operand_t field_src;
  operand_t field_dst;

  // 001 and 101 are illegal
  function automatic operand_t field_mode(input logic [2:0] field);
    case (field)
      3'b000:         field_mode = REG_A;
      3'b100:         field_mode = REG_SP;
      3'b011, 3'b111: field_mode = IMM;
      3'b010, 3'b110: field_mode = ADDRESS_IMM;
      default:        field_mode = UNUSED;
    endcase
  endfunction

  assign ins = opcode_byte;

  always_comb begin
    field_src = field_mode(ins.two_op.src);
    field_dst = field_mode(ins.two_op.dst);
    next_ope  = HLT;
    next_src  = UNUSED;
    next_dst  = UNUSED;
    if (ins.two_op.cls != 2'b11) begin
      if ((field_src != UNUSED) && (field_dst != UNUSED) && (field_dst != IMM)) begin
        case (ins.two_op.cls)
          2'b00:   next_ope = MOV;
          2'b01:   next_ope = ADD;
          default: next_ope = CMP;
        endcase
        next_src = field_src;
        next_dst = field_dst;
      end
    end else if ((ins.misc.group == 3'b010) && (ins.misc.sel == 3'b000)) begin
      next_ope = JMP;
      next_src = IMM;
    end else if ((ins.misc.group == 3'b111) && (ins.misc.sel == 3'b110)) begin
      next_ope = NOP;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decode_ope <= NOP;
      decode_src <= UNUSED;
      decode_dst <= UNUSED;
    end else if (stage == DECODE) begin
      decode_ope <= next_ope;
      decode_src <= next_src;
      decode_dst <= next_dst;
    end
  end

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
`default_nettype none

`include "cpu_settings.svh"

module execute_unit import cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  stage_t   stage
  , input  opcode_t  decode_ope
  , input  operand_t decode_src
  , input  operand_t decode_dst
  , input  word_t    imm
  , input  word_t    mem_src
  , input  word_t    mem_dst
  , output word_t    register_a
  , output word_t    register_sp
  , output word_t    register_flag
  , output word_t    result
);

  word_t               src;
  word_t               dst;
  word_t               neg_src;
  word_t               flag_word;
  word_t               pending_flag;
  logic [`CPU_WIDTH:0] sum_u;
  logic [`CPU_WIDTH:0] sum_s;
  logic [`CPU_WIDTH:0] ext_src;
  logic [`CPU_WIDTH:0] ext_dst;
  logic                writes_reg;

  always_comb begin
    case (decode_src)
      REG_A:       src = register_a;
      REG_SP:      src = register_sp;
      IMM:         src = imm;
      ADDRESS_IMM: src = mem_src;
      default:     src = '0;
    endcase
    case (decode_dst)
      REG_A:       dst = register_a;
      REG_SP:      dst = register_sp;
      ADDRESS_IMM: dst = mem_dst;
      default:     dst = '0;
    endcase
  end

  // Unsigned sum for carry, sign-extended sum for overflow
  assign neg_src = ~src + 1'b1;
  assign ext_src = {src[`CPU_WIDTH-1], src};
  assign ext_dst = {dst[`CPU_WIDTH-1], dst};

  always_comb begin
    if (decode_ope == CMP) begin
      sum_u = {1'b0, dst} + {1'b0, neg_src};
      sum_s = ext_dst - ext_src;
    end else begin
      sum_u = {1'b0, dst} + {1'b0, src};
      sum_s = ext_dst + ext_src;
    end
    flag_word = '0;
    flag_word[`CPU_FLAG_CARRY]     = sum_u[`CPU_WIDTH];
    flag_word[`CPU_FLAG_ZERO]      = ~|sum_u[`CPU_WIDTH-1:0];
    flag_word[`CPU_FLAG_SIGN]      = sum_u[`CPU_WIDTH-1];
    flag_word[`CPU_FLAG_OVERFLOW]  = !sum_s[`CPU_WIDTH] && sum_s[`CPU_WIDTH-1];
    flag_word[`CPU_FLAG_UNDERFLOW] = sum_s[`CPU_WIDTH] && !sum_s[`CPU_WIDTH-1];
  end

  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      case (decode_ope)
        MOV:     result <= src;
        ADD:     result <= sum_u[`CPU_WIDTH-1:0];
        default: begin
        end
      endcase
      if ((decode_ope == ADD) || (decode_ope == CMP)) begin
        pending_flag <= flag_word;
      end else begin
        pending_flag <= register_flag;
      end
    end
  end

  assign writes_reg = (stage == WRITE_REGISTER) && ((decode_ope == MOV) || (decode_ope == ADD));

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      register_a    <= '0;
      register_sp   <= `CPU_SP_RESET;
      register_flag <= '0;
    end else begin
      if (writes_reg && (decode_dst == REG_A)) begin
        register_a <= result;
      end
      if (writes_reg && (decode_dst == REG_SP)) begin
        register_sp <= result;
      end
      if (stage == WRITE_REGISTER) begin
        register_flag <= pending_flag;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bus_master.sv */
`default_nettype none

module bus_master import cpu_pkg::*; (
  input    logic      CLOCK
  , input  logic      RESET
  , input  stage_t    stage
  , input  word_t     read_addr
  , input  logic      reading
  , input  word_t     dst_addr
  , input  word_t     result
  , output word_t     addr_bus
  , output word_t     write_bus
  , output mem_ctrl_t ctrl_bus
  , output logic      store_done
);

  always_comb begin
    if (reading) begin
      addr_bus = read_addr;
      ctrl_bus = MEMORY_READ;
    end else if (stage == WRITE_MEMORY) begin
      addr_bus = dst_addr;
      ctrl_bus = MEMORY_WRITE;
    end else begin
      addr_bus = '0;
      ctrl_bus = MEMORY_STAY;
    end
  end

  // Single-cycle store
  assign store_done = (stage == WRITE_MEMORY);

  // Loaded one cycle ahead so data is valid with MEMORY_WRITE
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      write_bus <= '0;
    end else if (stage == WRITE_REGISTER) begin
      write_bus <= result;
    end
  end

  a_write_in_store: assert property (
    @(posedge CLOCK) disable iff (RESET)
    (ctrl_bus == MEMORY_WRITE) |->
      ((stage == WRITE_MEMORY) && ($past(stage) == WRITE_REGISTER))
  );

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`default_nettype none

module cpu import cpu_pkg::*; (
  input    logic      CLOCK
  , input  logic      RESET
  , input  word_t     read_bus
  , output word_t     addr_bus
  , output word_t     write_bus
  , output word_t     acc
  , output word_t     flags
  , output mem_ctrl_t ctrl_bus
  , output logic      halted
);

  stage_t   stage;
  logic     fetch_done;
  logic     store_done;
  logic     reading;
  word_t    opcode_byte;
  word_t    imm;
  word_t    mem_src;
  word_t    mem_dst;
  word_t    dst_addr;
  word_t    read_addr;
  word_t    result;
  opcode_t  decode_ope;
  operand_t decode_src;
  operand_t decode_dst;

  sequencer u_sequencer (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .fetch_done (fetch_done),
    .store_done (store_done),
    .decode_ope (decode_ope),
    .decode_dst (decode_dst),
    .stage      (stage),
    .halted     (halted)
  );

  operand_fetch u_operand_fetch (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .read_bus    (read_bus),
    .decode_ope  (decode_ope),
    .decode_src  (decode_src),
    .decode_dst  (decode_dst),
    .fetch_done  (fetch_done),
    .opcode_byte (opcode_byte),
    .imm         (imm),
    .mem_src     (mem_src),
    .mem_dst     (mem_dst),
    .dst_addr    (dst_addr),
    .read_addr   (read_addr),
    .reading     (reading)
  );

  decoder u_decoder (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .opcode_byte (opcode_byte),
    .decode_ope  (decode_ope),
    .decode_src  (decode_src),
    .decode_dst  (decode_dst)
  );

  // SP is internal only
  execute_unit u_execute_unit (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .stage         (stage),
    .decode_ope    (decode_ope),
    .decode_src    (decode_src),
    .decode_dst    (decode_dst),
    .imm           (imm),
    .mem_src       (mem_src),
    .mem_dst       (mem_dst),
    .register_a    (acc),
    .register_sp   (),
    .register_flag (flags),
    .result        (result)
  );

  bus_master u_bus_master (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .stage      (stage),
    .read_addr  (read_addr),
    .reading    (reading),
    .dst_addr   (dst_addr),
    .result     (result),
    .addr_bus   (addr_bus),
    .write_bus  (write_bus),
    .ctrl_bus   (ctrl_bus),
    .store_done (store_done)
  );

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam logic [1:0] CLS_MOV = 2'b00;
  localparam logic [1:0] CLS_ADD = 2'b01;
  localparam logic [1:0] CLS_CMP = 2'b10;
  localparam logic [2:0] FLD_A   = 3'b000;
  localparam logic [2:0] FLD_SP  = 3'b100;
  localparam logic [2:0] FLD_IMM = 3'b011;
  localparam logic [2:0] FLD_MEM = 3'b010;
  localparam word_t      JMP_BYTE = 8'hD0;
  localparam word_t      HLT_BYTE = 8'hFF;
  localparam int         CYCLES_PER_BYTE = 16;

  logic      CLOCK = 1'b0;
  logic      RESET;
  word_t     read_bus = '0;
  word_t     addr_bus;
  word_t     write_bus;
  word_t     acc;
  word_t     flags;
  mem_ctrl_t ctrl_bus;
  logic      halted;

  word_t       mem [0:255];
  word_t       write_addr_q [$];
  word_t       write_data_q [$];
  word_t       load_ptr;
  word_t       bus_addr;
  word_t       bus_data;
  mem_ctrl_t   bus_ctrl;
  logic [31:0] lcg_state;
  int          cycles;
  int          cycle_limit;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          reads_after_halt;

  cpu u_cpu (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .read_bus  (read_bus),
    .addr_bus  (addr_bus),
    .write_bus (write_bus),
    .acc       (acc),
    .flags     (flags),
    .ctrl_bus  (ctrl_bus),
    .halted    (halted)
  );

  always #10 CLOCK = ~CLOCK;

  // Memory answers one cycle after the address
  always @(posedge CLOCK) begin
    bus_addr = addr_bus;
    bus_ctrl = ctrl_bus;
    bus_data = write_bus;
    if ((halted === 1'b1) && (ctrl_bus == MEMORY_READ)) begin
      reads_after_halt = reads_after_halt + 1;
    end
    #1;
    if (bus_ctrl == MEMORY_READ) begin
      read_bus = mem[bus_addr];
    end else if (bus_ctrl == MEMORY_WRITE) begin
      mem[bus_addr] = bus_data;
      write_addr_q.push_back(bus_addr);
      write_data_q.push_back(bus_data);
    end
  end

  always @(posedge CLOCK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the CPU did not halt within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic word_t encode_two_op(input logic [1:0] cls, input logic [2:0] dst,
                                          input logic [2:0] src);
    return {cls, dst, src};
  endfunction

  // Target counts from the byte after the immediate
  function automatic word_t jump_target(input word_t at, input word_t offset);
    return at + 8'd2 + offset;
  endfunction

  function automatic word_t expected_flags(input logic is_cmp, input word_t d, input word_t s);
    int    wide;
    int    signed_sum;
    word_t low;
    word_t f;
    if (is_cmp) begin
      wide       = int'(d) + ((256 - int'(s)) % 256);
      signed_sum = int'($signed(d)) - int'($signed(s));
    end else begin
      wide       = int'(d) + int'(s);
      signed_sum = int'($signed(d)) + int'($signed(s));
    end
    low = wide[7:0];
    f = '0;
    f[`CPU_FLAG_CARRY]     = (wide > 255);
    f[`CPU_FLAG_ZERO]      = (low == 8'h00);
    f[`CPU_FLAG_SIGN]      = low[7];
    f[`CPU_FLAG_OVERFLOW]  = (signed_sum > 127);
    f[`CPU_FLAG_UNDERFLOW] = (signed_sum < -128);
    return f;
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_random_byte(output word_t value);
    lcg_state = lcg_step(lcg_state);
    value = lcg_state[23:16];
  endtask

  task automatic expect_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Error at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic expect_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %s FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic clear_memory();
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i] = i[7:0] ^ 8'hC3;
    end
    write_addr_q.delete();
    write_data_q.delete();
    load_ptr = '0;
  endtask

  // Every program byte extends the cycle budget
  task automatic emit(input word_t value);
    mem[load_ptr] = value;
    load_ptr = load_ptr + 1'b1;
    cycle_limit = cycle_limit + CYCLES_PER_BYTE;
  endtask

  task automatic apply_reset();
    RESET = 1'b1;
    repeat (4) @(posedge CLOCK);
    #1;
    RESET = 1'b0;
    reads_after_halt = 0;
  endtask

  task automatic wait_halted();
    do begin
      @(posedge CLOCK);
      #1;
    end while (halted !== 1'b1);
  endtask

  task automatic run_program();
    apply_reset();
    wait_halted();
  endtask

  task automatic confirm_parked();
    repeat (3) @(posedge CLOCK);
    #1;
    expect_word("halted", {7'b0, halted}, 8'h01);
    expect_count("reads after halt", reads_after_halt, 0);
  endtask

  task automatic reset_behavior();
    int errors_before;
    errors_before = errors;
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h5A);
    emit(encode_two_op(CLS_ADD, FLD_A, FLD_IMM));
    emit(8'h80);
    emit(HLT_BYTE);
    run_program();
    expect_word("acc before reset", acc, 8'h5A + 8'h80);
    expect_word("flags before reset", flags, expected_flags(1'b0, 8'h5A, 8'h80));
    // Reset a halted CPU that holds non-zero registers
    RESET = 1'b1;
    repeat (3) @(posedge CLOCK);
    #1;
    expect_word("ctrl_bus in reset", {6'b0, ctrl_bus}, {6'b0, MEMORY_STAY});
    expect_word("acc in reset", acc, 8'h00);
    expect_word("flags in reset", flags, 8'h00);
    expect_word("halted in reset", {7'b0, halted}, 8'h00);
    @(posedge CLOCK);
    #1;
    RESET = 1'b0;
    expect_word("ctrl_bus after reset", {6'b0, ctrl_bus}, {6'b0, MEMORY_STAY});
    @(posedge CLOCK);
    #1;
    expect_word("first ctrl_bus", {6'b0, ctrl_bus}, {6'b0, MEMORY_READ});
    expect_word("first read address", addr_bus, 8'h00);
    wait_halted();
    expect_word("acc after rerun", acc, 8'h5A + 8'h80);
    finish_test("reset_behavior", errors_before);
  endtask

  task automatic register_moves();
    int errors_before;
    errors_before = errors;
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h9C);
    emit(encode_two_op(CLS_ADD, FLD_A, FLD_IMM));
    emit(8'h7B);
    emit(HLT_BYTE);
    run_program();
    expect_word("acc after add", acc, 8'h9C + 8'h7B);
    confirm_parked();
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_SP, FLD_IMM));
    emit(8'h3E);
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h55);
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_SP));
    emit(HLT_BYTE);
    run_program();
    expect_word("acc from SP", acc, 8'h3E);
    confirm_parked();
    finish_test("register_moves", errors_before);
  endtask

  task automatic run_flag_case(input logic is_cmp, input word_t d, input word_t s);
    word_t exp_acc;
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(d);
    emit(encode_two_op(is_cmp ? CLS_CMP : CLS_ADD, FLD_A, FLD_IMM));
    emit(s);
    emit(HLT_BYTE);
    run_program();
    if (is_cmp) begin
      exp_acc = d;
    end else begin
      exp_acc = d + s;
    end
    expect_word("flags", flags, expected_flags(is_cmp, d, s));
    expect_word("acc", acc, exp_acc);
  endtask

  task automatic flag_results();
    int errors_before;
    errors_before = errors;
    run_flag_case(1'b0, 8'h7F, 8'h01);
    run_flag_case(1'b0, 8'hFF, 8'h01);
    run_flag_case(1'b0, 8'h80, 8'h80);
    run_flag_case(1'b0, 8'h12, 8'h34);
    run_flag_case(1'b1, 8'h10, 8'h10);
    // Subtracting zero gives no carry
    run_flag_case(1'b1, 8'h05, 8'h00);
    run_flag_case(1'b1, 8'h7F, 8'h80);
    run_flag_case(1'b1, 8'h80, 8'h01);
    run_flag_case(1'b1, 8'h03, 8'h09);
    finish_test("flag_results", errors_before);
  endtask

  task automatic memory_operands();
    int    errors_before;
    word_t old_byte;
    word_t sum_byte;
    errors_before = errors;
    old_byte = 8'hFE;
    sum_byte = old_byte + 8'h05;
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_MEM, FLD_IMM));
    emit(8'h3C);
    emit(8'h80);
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h10);
    emit(encode_two_op(CLS_ADD, FLD_A, FLD_MEM));
    emit(8'h90);
    emit(encode_two_op(CLS_ADD, FLD_MEM, FLD_IMM));
    emit(8'h05);
    emit(8'hA0);
    emit(HLT_BYTE);
    mem[8'h90] = 8'h21;
    mem[8'hA0] = old_byte;
    run_program();
    expect_count("write count", write_addr_q.size(), 2);
    if (write_addr_q.size() == 2) begin
      expect_word("first write address", write_addr_q[0], 8'h80);
      expect_word("first write data", write_data_q[0], 8'h3C);
      expect_word("second write address", write_addr_q[1], 8'hA0);
      expect_word("second write data", write_data_q[1], sum_byte);
    end
    expect_word("acc after memory add", acc, 8'h10 + 8'h21);
    expect_word("flags after memory add", flags, expected_flags(1'b0, old_byte, 8'h05));
    expect_word("stored byte", mem[8'hA0], sum_byte);
    finish_test("memory_operands", errors_before);
  endtask

  task automatic jump_and_illegal();
    int errors_before;
    errors_before = errors;
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h11);
    emit(JMP_BYTE);
    emit(8'hF0);
    // Reached only by the second jump
    emit(encode_two_op(CLS_ADD, FLD_A, FLD_IMM));
    emit(8'h20);
    emit(HLT_BYTE);
    load_ptr = jump_target(8'h02, 8'hF0);
    emit(encode_two_op(CLS_ADD, FLD_A, FLD_IMM));
    emit(8'h01);
    // Wraps past 0xFF back to address 4
    emit(JMP_BYTE);
    emit(8'h04 - (load_ptr + 8'd1));
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h99);
    run_program();
    expect_word("acc after jumps", acc, 8'h11 + 8'h01 + 8'h20);
    clear_memory();
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h44);
    emit(8'h01);
    emit(encode_two_op(CLS_MOV, FLD_A, FLD_IMM));
    emit(8'h77);
    emit(HLT_BYTE);
    run_program();
    confirm_parked();
    expect_word("acc after illegal opcode", acc, 8'h44);
    finish_test("jump_and_illegal", errors_before);
  endtask

  task automatic random_add_chain();
    int    errors_before;
    int    i;
    word_t value;
    word_t model_acc;
    word_t model_flags;
    errors_before = errors;
    model_acc = '0;
    model_flags = '0;
    clear_memory();
    for (i = 0; i < 20; i++) begin
      next_random_byte(value);
      emit(encode_two_op(CLS_ADD, FLD_A, FLD_IMM));
      emit(value);
      model_flags = expected_flags(1'b0, model_acc, value);
      model_acc = model_acc + value;
    end
    emit(HLT_BYTE);
    run_program();
    expect_word("acc after chain", acc, model_acc);
    expect_word("flags after chain", flags, model_flags);
    finish_test("random_add_chain", errors_before);
  endtask

  initial begin
    RESET = 1'b1;
    cycles = 0;
    cycle_limit = 100;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    reads_after_halt = 0;
    lcg_state = 32'h2673_4edd;
    load_ptr = '0;
    reset_behavior();
    register_moves();
    flag_results();
    memory_operands();
    jump_and_illegal();
    random_add_chain();
    $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/sequencer.sv
verilog/operand_fetch.sv
verilog/decoder.sv
verilog/execute_unit.sv
verilog/bus_master.sv
verilog/cpu.sv
bench/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -Mdir obj_dir

# The simulation may stop early on an assertion, so its status is not trusted alone
output=$(./obj_dir/Vcpu_tb || true)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
